// ==== source/exe_pkg.sv ====
// --------------------
// Shared widths, operation encodings and stage payloads of the integer
// execute subsystem. Modules take it by a wildcard import in their header.
// --------------------
package exe_pkg;

    localparam int XLEN      = 32;
    localparam int NREGS     = 32;
    localparam int REG_W     = 5;
    localparam int DIV_STEPS = XLEN;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_BRANCH,
        UNIT_DIV
    } unit_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } branch_op_t;

    // --------------------
    // Stage payloads
    // --------------------
    typedef struct packed {
        unit_t             unit;
        alu_op_t           alu_op;
        branch_op_t        branch_op;
        logic [REG_W-1:0]  rs1;
        logic [REG_W-1:0]  rs2;
        logic [REG_W-1:0]  rd;
        logic              use_imm;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   pc;
        logic              div_signed;
        logic              div_rem;
    } dec_instr_t;

    typedef struct packed {
        unit_t             unit;
        alu_op_t           alu_op;
        branch_op_t        branch_op;
        logic [REG_W-1:0]  rd;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   pc;
        logic              div_signed;
        logic              div_rem;
        logic [XLEN-1:0]   data_rs1;
        logic [XLEN-1:0]   data_rs2;
        // Immediate or rs2
        logic [XLEN-1:0]   data_op2;
    } exe_instr_t;

    typedef struct packed {
        logic [REG_W-1:0]  rd;
        logic              we;
        logic [XLEN-1:0]   result_rd;
        logic              taken;
        logic [XLEN-1:0]   target;
    } wb_instr_t;

    // Non-zero rd and not a conditional branch
    function automatic logic writes_rd(unit_t unit, branch_op_t op, logic [REG_W-1:0] rd);
        return (rd != '0) && !(unit == UNIT_BRANCH && op != BR_JAL && op != BR_JALR);
    endfunction

endpackage

// ==== source/pipe_reg.sv ====
// --------------------
// One-entry valid/ready register stage for any payload type.
// Accepts a new item in the cycle the held one leaves.
// --------------------
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    // Empty, or the held item leaves this cycle
    assign ready_o = !valid_q || ready_i;
    assign valid_o = valid_q;
    assign data_o  = data_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

// ==== source/alu.sv ====
// --------------------
// Single-cycle integer ALU
// Arithmetic, logic, shifts and set-less-than on two 32-bit operands
// --------------------
`timescale 1ns/1ps

module alu import exe_pkg::*; (
    input  alu_op_t         op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic [XLEN-1:0] result_o
);

    logic [4:0] shamt;

    // Only the low five bits count as a shift amount
    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                result_o = a_i + b_i;
            end
            ALU_SUB: begin
                result_o = a_i - b_i;
            end
            ALU_AND: begin
                result_o = a_i & b_i;
            end
            ALU_OR: begin
                result_o = a_i | b_i;
            end
            ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            ALU_SLL: begin
                result_o = a_i << shamt;
            end
            ALU_SRL: begin
                result_o = a_i >> shamt;
            end
            ALU_SRA: begin
                result_o = $unsigned($signed(a_i) >>> shamt);
            end
            ALU_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            end
            ALU_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, a_i < b_i};
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== source/branch_unit.sv ====
// --------------------
// Branch and jump evaluation. Gives the taken flag, the target
// and the link value pc+4
// --------------------
`timescale 1ns/1ps

module branch_unit import exe_pkg::*; (
    input  branch_op_t      op_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    input  logic [XLEN-1:0] imm_i,
    output logic            taken_o,
    output logic [XLEN-1:0] target_o,
    output logic [XLEN-1:0] link_o
);

    logic [XLEN-1:0] jalr_sum;

    assign jalr_sum = rs1_i + imm_i;

    always_comb begin
        case (op_i)
            BR_EQ:   taken_o = (rs1_i == rs2_i);
            BR_NE:   taken_o = (rs1_i != rs2_i);
            BR_LT:   taken_o = ($signed(rs1_i) < $signed(rs2_i));
            BR_GE:   taken_o = ($signed(rs1_i) >= $signed(rs2_i));
            BR_LTU:  taken_o = (rs1_i < rs2_i);
            BR_GEU:  taken_o = (rs1_i >= rs2_i);
            default: taken_o = 1'b1;
        endcase
    end

    // JALR clears bit 0 of the sum
    assign target_o = (op_i == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;
    assign link_o   = pc_i + XLEN'(4);

endmodule

// ==== source/div_unit.sv ====
// --------------------
// Iterative radix-2 divider, one quotient bit per cycle.
// Pulse start_i once, results are valid while done_o is high.
// --------------------
`timescale 1ns/1ps

module div_unit import exe_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            start_i,
    input  logic            signed_i,
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,
    output logic            busy_o,
    output logic            done_o,
    output logic [XLEN-1:0] quotient_o,
    output logic [XLEN-1:0] remainder_o
);

    logic                         busy_q;
    logic                         done_q;
    logic [$clog2(DIV_STEPS)-1:0] count_q;
    logic [XLEN-1:0]              quot_q;
    logic [XLEN-1:0]              rem_q;
    logic [XLEN-1:0]              divisor_q;
    logic                         neg_quot_q;
    logic                         neg_rem_q;
    logic                         running;
    logic [XLEN:0]                trial;
    logic                         fits;

    assign running = busy_q && !done_q;

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            count_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q  <= 1'b1;
                count_q <= '0;
            end else if (done_q) begin
                busy_q <= 1'b0;
            end else if (running) begin
                count_q <= count_q + 1'b1;
                done_q  <= (count_q == DIV_STEPS - 1);
            end
        end
    end

    // Shift-subtract on magnitudes
    assign trial = {rem_q, quot_q[XLEN-1]};
    assign fits  = (trial >= {1'b0, divisor_q});

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            quot_q    <= (signed_i && dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
            divisor_q <= (signed_i && divisor_i[XLEN-1]) ? -divisor_i : divisor_i;
            rem_q     <= '0;
            // Zero divisor keeps the all-ones quotient unsigned
            neg_quot_q <= signed_i && (dividend_i[XLEN-1] ^ divisor_i[XLEN-1]) &&
                          (divisor_i != '0);
            neg_rem_q  <= signed_i && dividend_i[XLEN-1];
        end else if (running) begin
            rem_q  <= fits ? XLEN'(trial - {1'b0, divisor_q}) : trial[XLEN-1:0];
            quot_q <= {quot_q[XLEN-2:0], fits};
        end
    end

    // Most negative over -1 falls out as the dividend with zero remainder
    assign quotient_o  = neg_quot_q ? -quot_q : quot_q;
    assign remainder_o = neg_rem_q ? -rem_q : rem_q;
    assign busy_o      = busy_q;
    assign done_o      = done_q;

    a_no_restart: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        busy_o |-> !start_i);

endmodule

// ==== source/operand_read.sv ====
// --------------------
// Register file with busy scoreboard. Reads the sources of a decoded
// instruction, bypasses a same-cycle writeback and holds back hazards.
// --------------------
`timescale 1ns/1ps

module operand_read import exe_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       valid_i,
    output logic       ready_o,
    input  dec_instr_t instr_i,
    output logic       valid_o,
    input  logic       ready_i,
    output exe_instr_t instr_o,
    input  logic       wb_valid_i,
    input  wb_instr_t  wb_i
);

    logic [XLEN-1:0]  rf_q [NREGS];
    logic [NREGS-1:0] busy_q;
    logic             wb_write;
    logic             cond_branch;
    logic             use_rs1;
    logic             use_rs2;
    logic             writes;
    logic             hazard;
    logic [XLEN-1:0]  rs1_data;
    logic [XLEN-1:0]  rs2_data;

    assign wb_write = wb_valid_i && wb_i.we && (wb_i.rd != '0);

    // x0 reads zero, a landing write wins over the array
    assign rs1_data = (instr_i.rs1 == '0) ? '0 :
                      (wb_write && wb_i.rd == instr_i.rs1) ? wb_i.result_rd : rf_q[instr_i.rs1];
    assign rs2_data = (instr_i.rs2 == '0) ? '0 :
                      (wb_write && wb_i.rd == instr_i.rs2) ? wb_i.result_rd : rf_q[instr_i.rs2];

    // --------------------
    // Interlock
    // --------------------
    assign cond_branch = (instr_i.unit == UNIT_BRANCH) &&
                         (instr_i.branch_op != BR_JAL) && (instr_i.branch_op != BR_JALR);
    assign use_rs1 = !(instr_i.unit == UNIT_BRANCH && instr_i.branch_op == BR_JAL);
    assign use_rs2 = !instr_i.use_imm || cond_branch;
    assign writes  = writes_rd(instr_i.unit, instr_i.branch_op, instr_i.rd);

    // rd is checked too, so a register has at most one producer in flight
    assign hazard = (use_rs1 && busy_q[instr_i.rs1] && !(wb_write && wb_i.rd == instr_i.rs1)) ||
                    (use_rs2 && busy_q[instr_i.rs2] && !(wb_write && wb_i.rd == instr_i.rs2)) ||
                    (writes  && busy_q[instr_i.rd]  && !(wb_write && wb_i.rd == instr_i.rd));

    assign valid_o = valid_i && !hazard;
    assign ready_o = ready_i && !hazard;

    always_comb begin
        instr_o.unit       = instr_i.unit;
        instr_o.alu_op     = instr_i.alu_op;
        instr_o.branch_op  = instr_i.branch_op;
        instr_o.rd         = instr_i.rd;
        instr_o.imm        = instr_i.imm;
        instr_o.pc         = instr_i.pc;
        instr_o.div_signed = instr_i.div_signed;
        instr_o.div_rem    = instr_i.div_rem;
        instr_o.data_rs1   = rs1_data;
        instr_o.data_rs2   = rs2_data;
        instr_o.data_op2   = instr_i.use_imm ? instr_i.imm : rs2_data;
    end

    // Registers read zero out of reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (wb_write) begin
            rf_q[wb_i.rd] <= wb_i.result_rd;
        end
    end

    // A new producer sets its bit after the retiring one clears it
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= '0;
        end else begin
            if (wb_write) begin
                busy_q[wb_i.rd] <= 1'b0;
            end
            if (valid_o && ready_i && writes) begin
                busy_q[instr_i.rd] <= 1'b1;
            end
        end
    end

    a_write_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_write |-> busy_q[wb_i.rd]);

endmodule

// ==== source/exe_stage.sv ====
// --------------------
// Execute stage. Steers an operand-carrying instruction to the ALU,
// branch unit or divider and forms the writeback payload.
// --------------------
`timescale 1ns/1ps

module exe_stage import exe_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       valid_i,
    output logic       ready_o,
    input  exe_instr_t instr_i,
    output logic       valid_o,
    input  logic       ready_i,
    output wb_instr_t  wb_o
);

    logic            is_div;
    logic            is_branch;
    logic            started_q;
    logic            div_start;
    logic            div_done;
    logic [XLEN-1:0] alu_result;
    logic            br_taken;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] br_link;
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;

    assign is_div    = (instr_i.unit == UNIT_DIV);
    assign is_branch = (instr_i.unit == UNIT_BRANCH);

    alu alu_inst (
        .op_i     (instr_i.alu_op),
        .a_i      (instr_i.data_rs1),
        .b_i      (instr_i.data_op2),
        .result_o (alu_result)
    );

    branch_unit branch_unit_inst (
        .op_i     (instr_i.branch_op),
        .pc_i     (instr_i.pc),
        .rs1_i    (instr_i.data_rs1),
        .rs2_i    (instr_i.data_rs2),
        .imm_i    (instr_i.imm),
        .taken_o  (br_taken),
        .target_o (br_target),
        .link_o   (br_link)
    );

    // --------------------
    // Divider run
    // --------------------
    assign div_start = valid_i && is_div && ready_i && !started_q;

    div_unit div_unit_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .start_i     (div_start),
        .signed_i    (instr_i.div_signed),
        .dividend_i  (instr_i.data_rs1),
        .divisor_i   (instr_i.data_op2),
        .busy_o      (),
        .done_o      (div_done),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            started_q <= 1'b0;
        end else if (div_start) begin
            started_q <= 1'b1;
        end else if (div_done) begin
            started_q <= 1'b0;
        end
    end

    // Division holds the handshake until the done pulse
    assign valid_o = valid_i && (!is_div || div_done);
    assign ready_o = ready_i && (!is_div || div_done);

    always_comb begin
        wb_o.rd     = instr_i.rd;
        wb_o.we     = writes_rd(instr_i.unit, instr_i.branch_op, instr_i.rd);
        wb_o.taken  = is_branch && br_taken;
        wb_o.target = is_branch ? br_target : '0;
        case (instr_i.unit)
            UNIT_ALU:    wb_o.result_rd = alu_result;
            UNIT_BRANCH: wb_o.result_rd = (instr_i.branch_op == BR_JAL ||
                                           instr_i.branch_op == BR_JALR) ? br_link : '0;
            UNIT_DIV:    wb_o.result_rd = instr_i.div_rem ? remainder : quotient;
            default:     wb_o.result_rd = '0;
        endcase
    end

    // Done pulse comes DIV_STEPS+1 cycles after the start
    a_div_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        div_start |-> ##(DIV_STEPS+1) div_done);

endmodule

// ==== source/exe_top.sv ====
// --------------------
// Integer execute subsystem top. Chains input register, operand read,
// operand register, execute stage and output register.
// --------------------
`timescale 1ns/1ps

module exe_top import exe_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       dec_valid_i,
    output logic       dec_ready_o,
    input  dec_instr_t dec_i,
    output logic       wb_valid_o,
    input  logic       wb_ready_i,
    output wb_instr_t  wb_o
);

    logic       dec_valid;
    logic       dec_ready;
    dec_instr_t dec_instr;
    logic       rd_valid;
    logic       rd_ready;
    exe_instr_t rd_instr;
    logic       op_valid;
    logic       op_ready;
    exe_instr_t op_instr;
    logic       ex_valid;
    logic       ex_ready;
    wb_instr_t  ex_wb;

    pipe_reg #(.payload_t(dec_instr_t)) in_reg (
        .clk_i, .arst_n_i,
        .valid_i (dec_valid_i), .ready_o (dec_ready_o), .data_i (dec_i),
        .valid_o (dec_valid),   .ready_i (dec_ready),   .data_o (dec_instr)
    );

    // Register file write port fed back from the writeback transfer
    operand_read operand_read_inst (
        .clk_i, .arst_n_i,
        .valid_i    (dec_valid), .ready_o (dec_ready), .instr_i (dec_instr),
        .valid_o    (rd_valid),  .ready_i (rd_ready),  .instr_o (rd_instr),
        .wb_valid_i (wb_valid_o && wb_ready_i),
        .wb_i       (wb_o)
    );

    pipe_reg #(.payload_t(exe_instr_t)) op_reg (
        .clk_i, .arst_n_i,
        .valid_i (rd_valid), .ready_o (rd_ready), .data_i (rd_instr),
        .valid_o (op_valid), .ready_i (op_ready), .data_o (op_instr)
    );

    exe_stage exe_stage_inst (
        .clk_i, .arst_n_i,
        .valid_i (op_valid), .ready_o (op_ready), .instr_i (op_instr),
        .valid_o (ex_valid), .ready_i (ex_ready), .wb_o    (ex_wb)
    );

    pipe_reg #(.payload_t(wb_instr_t)) out_reg (
        .clk_i, .arst_n_i,
        .valid_i (ex_valid),   .ready_o (ex_ready),   .data_i (ex_wb),
        .valid_o (wb_valid_o), .ready_i (wb_ready_i), .data_o (wb_o)
    );

endmodule

// ==== tests/exe_model.svh ====
// --------------------
// Reference model of the register file and instruction semantics.
// Included inside the testbench module, updated in program order.
// --------------------
`ifndef EXE_MODEL_SVH
`define EXE_MODEL_SVH

logic [XLEN-1:0] model_rf [NREGS] = '{default: '0};

function automatic logic [XLEN-1:0] compute_alu(alu_op_t op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
    case (op)
        ALU_ADD:  return a + b;
        ALU_SUB:  return a - b;
        ALU_AND:  return a & b;
        ALU_OR:   return a | b;
        ALU_XOR:  return a ^ b;
        ALU_SLL:  return a << (b % 32);
        ALU_SRL:  return a >> (b % 32);
        ALU_SRA:  return $unsigned($signed(a) >>> (b % 32));
        ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
        default:  return '0;
    endcase
endfunction

// RISC-V division rules, including the two corner cases
function automatic logic [XLEN-1:0] divide_riscv(logic sgn, logic rem, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b);
    if (b == '0) begin
        return rem ? a : {XLEN{1'b1}};
    end
    if (sgn && a == 32'h8000_0000 && b == {XLEN{1'b1}}) begin
        return rem ? '0 : a;
    end
    if (sgn) begin
        return rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
    end
    return rem ? a % b : a / b;
endfunction

function automatic logic branch_taken(branch_op_t op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    case (op)
        BR_EQ:   return a == b;
        BR_NE:   return a != b;
        BR_LT:   return $signed(a) < $signed(b);
        BR_GE:   return $signed(a) >= $signed(b);
        BR_LTU:  return a < b;
        BR_GEU:  return a >= b;
        default: return 1'b1;
    endcase
endfunction

// Expected writeback of one instruction, applied to the model registers
function automatic wb_instr_t execute_instr(dec_instr_t d);
    wb_instr_t       e;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] r2;
    logic [XLEN-1:0] b;
    logic            link;
    a    = model_rf[d.rs1];
    r2   = model_rf[d.rs2];
    b    = d.use_imm ? d.imm : r2;
    link = (d.branch_op == BR_JAL) || (d.branch_op == BR_JALR);
    e    = '0;
    e.rd = d.rd;
    if (d.unit == UNIT_ALU) begin
        e.result_rd = compute_alu(d.alu_op, a, b);
    end else if (d.unit == UNIT_DIV) begin
        e.result_rd = divide_riscv(d.div_signed, d.div_rem, a, b);
    end else if (d.unit == UNIT_BRANCH) begin
        e.taken     = branch_taken(d.branch_op, a, r2);
        e.target    = (d.branch_op == BR_JALR) ? ((a + d.imm) & ~32'h1) : d.pc + d.imm;
        e.result_rd = link ? d.pc + 32'd4 : '0;
    end
    e.we = (d.rd != '0) && (d.unit != UNIT_BRANCH || link);
    if (e.we) begin
        model_rf[d.rd] = e.result_rd;
    end
    return e;
endfunction

`endif

// ==== tests/tb_exe_top.sv ====
// --------------------
// Testbench for the execute subsystem. Directed and random instructions
// with random back-pressure, checked in order against the reference model.
// --------------------
`timescale 1ns/1ps

module tb_exe_top import exe_pkg::*; ();

    localparam int N_RANDOM    = 300;
    localparam int WAIT_LIMIT  = 500;
    localparam int DRAIN_LIMIT = 4000;
    localparam int BP_LEN      = 4096;

    logic       clk_i;
    logic       arst_n_i;
    logic       dec_valid_i;
    logic       dec_ready_o;
    dec_instr_t dec_i;
    logic       wb_valid_o;
    logic       wb_ready_i;
    wb_instr_t  wb_o;

    logic [31:0] rng_state;
    dec_instr_t  stim_q[$];
    bit          gap_q[$];
    wb_instr_t   expected_q[$];
    bit          bp_pattern [BP_LEN];
    int          bp_index;
    int          in_count;
    int          out_count;
    int          value_errors;
    int          protocol_errors;
    int          timeouts;
    bit          hold_pending;
    wb_instr_t   held_wb;

    `include "exe_model.svh"

    exe_top exe_top_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .dec_valid_i (dec_valid_i),
        .dec_ready_o (dec_ready_o),
        .dec_i       (dec_i),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i),
        .wb_o        (wb_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // --------------------
    // Random stimulus
    // --------------------
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic dec_instr_t make_instr(unit_t unit, alu_op_t aop, branch_op_t bop,
                                              int rd, int rs1, int rs2, bit use_imm,
                                              logic [31:0] imm, bit sgn, bit rem);
        dec_instr_t d;
        d            = '0;
        d.unit       = unit;
        d.alu_op     = aop;
        d.branch_op  = bop;
        d.rd         = REG_W'(rd);
        d.rs1        = REG_W'(rs1);
        d.rs2        = REG_W'(rs2);
        d.use_imm    = use_imm;
        d.imm        = imm;
        d.pc         = xorshift32() & 32'hffff_fffc;
        d.div_signed = sgn;
        d.div_rem    = rem;
        return d;
    endfunction

    // Corner values show up often
    function automatic logic [31:0] pick_imm();
        case (xorshift32() % 6)
            0:       return 32'h0;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return xorshift32() % 64;
            default: return xorshift32();
        endcase
    endfunction

    function automatic dec_instr_t random_instr();
        dec_instr_t  d;
        logic [31:0] pick;
        d            = '0;
        d.alu_op     = alu_op_t'(4'(xorshift32() % 10));
        d.branch_op  = branch_op_t'(3'(xorshift32() % 8));
        d.rs1        = REG_W'(xorshift32() % 8);
        d.rs2        = REG_W'(xorshift32() % 8);
        d.rd         = REG_W'(xorshift32() % 8);
        d.use_imm    = (xorshift32() % 2) == 1;
        d.imm        = pick_imm();
        d.pc         = xorshift32() & 32'hffff_fffc;
        d.div_signed = (xorshift32() % 2) == 1;
        d.div_rem    = (xorshift32() % 2) == 1;
        pick         = xorshift32() % 8;
        if (pick < 5) begin
            d.unit = UNIT_ALU;
        end else if (pick < 7) begin
            d.unit = UNIT_BRANCH;
        end else begin
            d.unit = UNIT_DIV;
        end
        return d;
    endfunction

    task automatic build_stimulus();
        // Zero registers, division corners, dependent chains, x0 writes, jumps
        stim_q.push_back(make_instr(UNIT_ALU, ALU_ADD, BR_EQ, 3, 1, 2, 0, 0, 0, 0));
        stim_q.push_back(make_instr(UNIT_ALU, ALU_ADD, BR_EQ, 5, 0, 0, 1, 32'h8000_0000, 0, 0));
        stim_q.push_back(make_instr(UNIT_DIV, ALU_ADD, BR_EQ, 6, 5, 0, 1, 32'hffff_ffff, 1, 0));
        stim_q.push_back(make_instr(UNIT_DIV, ALU_ADD, BR_EQ, 7, 5, 0, 1, 32'hffff_ffff, 1, 1));
        stim_q.push_back(make_instr(UNIT_DIV, ALU_ADD, BR_EQ, 4, 5, 0, 1, 32'h0, 0, 0));
        stim_q.push_back(make_instr(UNIT_DIV, ALU_ADD, BR_EQ, 4, 5, 0, 1, 32'h0, 1, 1));
        stim_q.push_back(make_instr(UNIT_DIV, ALU_ADD, BR_EQ, 2, 5, 0, 1, 32'd7, 1, 0));
        stim_q.push_back(make_instr(UNIT_ALU, ALU_ADD, BR_EQ, 1, 4, 0, 1, 32'd1, 0, 0));
        stim_q.push_back(make_instr(UNIT_ALU, ALU_SUB, BR_EQ, 1, 1, 6, 0, 0, 0, 0));
        stim_q.push_back(make_instr(UNIT_ALU, ALU_ADD, BR_EQ, 0, 1, 0, 1, 32'd5, 0, 0));
        stim_q.push_back(make_instr(UNIT_ALU, ALU_ADD, BR_EQ, 2, 0, 0, 0, 0, 0, 0));
        stim_q.push_back(make_instr(UNIT_ALU, ALU_SLL, BR_EQ, 3, 1, 0, 1, 32'h23, 0, 0));
        stim_q.push_back(make_instr(UNIT_ALU, ALU_SLT, BR_EQ, 3, 5, 1, 0, 0, 0, 0));
        stim_q.push_back(make_instr(UNIT_ALU, ALU_SLTU, BR_EQ, 3, 5, 1, 0, 0, 0, 0));
        stim_q.push_back(make_instr(UNIT_BRANCH, ALU_ADD, BR_JAL, 1, 0, 0, 1, 32'h20, 0, 0));
        stim_q.push_back(make_instr(UNIT_BRANCH, ALU_ADD, BR_JALR, 2, 1, 0, 1, 32'd3, 0, 0));
        stim_q.push_back(make_instr(UNIT_BRANCH, ALU_ADD, BR_NE, 3, 0, 5, 1, 32'h40, 0, 0));
        for (int i = 0; i < N_RANDOM; i++) begin
            stim_q.push_back(random_instr());
        end
        foreach (stim_q[i]) begin
            gap_q.push_back((xorshift32() % 5) == 0);
        end
        foreach (bp_pattern[i]) begin
            bp_pattern[i] = (xorshift32() % 4) != 0;
        end
    endtask

    // --------------------
    // Reporting
    // --------------------
    task automatic print_summary();
        $display("Summary: %0d of %0d outputs, %0d value errors, %0d protocol errors, %0d timeouts",
                 out_count, in_count, value_errors, protocol_errors, timeouts);
    endtask

    task automatic stall_abort(input string what);
        $display("Timeout: %s", what);
        timeouts++;
        print_summary();
        $display("** FAIL **");
        $finish;
    endtask

    task automatic report_and_finish();
        if (expected_q.size() != 0 || out_count != stim_q.size()) begin
            $display("Output count %0d does not match %0d instructions sent",
                     out_count, stim_q.size());
            protocol_errors++;
        end
        print_summary();
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic check_output(input wb_instr_t got);
        wb_instr_t exp;
        if (expected_q.size() == 0) begin
            $display("Writeback transfer with no instruction outstanding");
            protocol_errors++;
            return;
        end
        exp = expected_q.pop_front();
        out_count++;
        if (got.rd !== exp.rd) begin
            $display("ERROR wb_o.rd: got %h expected %h", got.rd, exp.rd);
            value_errors++;
        end
        if (got.we !== exp.we) begin
            $display("ERROR wb_o.we: got %h expected %h", got.we, exp.we);
            value_errors++;
        end
        if (got.result_rd !== exp.result_rd) begin
            $display("ERROR wb_o.result_rd: got %h expected %h", got.result_rd, exp.result_rd);
            value_errors++;
        end
        if (got.taken !== exp.taken) begin
            $display("ERROR wb_o.taken: got %h expected %h", got.taken, exp.taken);
            value_errors++;
        end
        if (got.target !== exp.target) begin
            $display("ERROR wb_o.target: got %h expected %h", got.target, exp.target);
            value_errors++;
        end
    endtask

    // --------------------
    // Driver, back-pressure and monitor
    // --------------------
    task automatic send_instr(input dec_instr_t d, input bit gap, output bit accepted);
        int waited;
        if (gap) begin
            dec_valid_i <= 1'b0;
            @(posedge clk_i);
        end
        dec_valid_i <= 1'b1;
        dec_i       <= d;
        accepted = 1'b0;
        waited   = 0;
        while (!accepted && waited < WAIT_LIMIT) begin
            @(posedge clk_i);
            accepted = dec_ready_o;
            waited++;
        end
        if (accepted) begin
            // Model runs at acceptance, outputs follow in the same order
            expected_q.push_back(execute_instr(d));
            in_count++;
        end
    endtask

    always @(posedge clk_i) begin
        wb_ready_i <= bp_pattern[bp_index];
        bp_index = (bp_index + 1) % BP_LEN;
    end

    // Values read here are those before the edge
    always @(posedge clk_i) begin
        if (arst_n_i) begin
            if (hold_pending) begin
                if (!wb_valid_o) begin
                    $display("wb_valid_o dropped before its item was taken");
                    protocol_errors++;
                end else if (wb_o !== held_wb) begin
                    $display("ERROR wb_o: got %h expected %h", wb_o, held_wb);
                    value_errors++;
                end
            end
            hold_pending = wb_valid_o && !wb_ready_i;
            held_wb      = wb_o;
            if (wb_valid_o && wb_ready_i) begin
                check_output(wb_o);
            end
        end
    end

    initial begin
        int waited;
        int sent;
        bit accepted;
        rng_state   = 32'd40935;
        bp_index    = 0;
        arst_n_i    = 1'b0;
        dec_valid_i = 1'b0;
        dec_i       = '0;
        wb_ready_i  = 1'b0;
        build_stimulus();
        repeat (2) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(posedge clk_i);
        if (wb_valid_o !== 1'b0) begin
            $display("ERROR wb_valid_o: got %h expected %h", wb_valid_o, 1'b0);
            value_errors++;
        end
        if (dec_ready_o !== 1'b1) begin
            $display("ERROR dec_ready_o: got %h expected %h", dec_ready_o, 1'b1);
            value_errors++;
        end
        accepted = 1'b1;
        sent     = 0;
        while (accepted && sent < stim_q.size()) begin
            send_instr(stim_q[sent], gap_q[sent], accepted);
            sent++;
        end
        dec_valid_i <= 1'b0;
        if (!accepted) begin
            stall_abort("dec_ready_o stayed low while an instruction waited at the input");
        end else begin
            waited = 0;
            while (out_count < in_count && waited < DRAIN_LIMIT) begin
                @(posedge clk_i);
                waited++;
            end
            if (out_count < in_count) begin
                stall_abort("writeback stopped before all instructions came back");
            end else begin
                // Idle tail catches any extra output
                repeat (20) @(posedge clk_i);
                report_and_finish();
            end
        end
    end

endmodule

// ==== sources.f ====
+incdir+tests
source/exe_pkg.sv
source/pipe_reg.sv
source/alu.sv
source/branch_unit.sv
source/div_unit.sv
source/operand_read.sv
source/exe_stage.sv
source/exe_top.sv
tests/tb_exe_top.sv

// ==== Bender.yml ====
package:
  name: exe_subsystem

sources:
  - files:
      - source/exe_pkg.sv
      - source/pipe_reg.sv
      - source/alu.sv
      - source/branch_unit.sv
      - source/div_unit.sv
      - source/operand_read.sv
      - source/exe_stage.sv
      - source/exe_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_exe_top.sv
